// ==== verilog.f ====
+incdir+.
lb_bus_pkg.sv
lb_addr_decode.sv
lb_ctrl_regs.sv
lb_mirror_ram.sv
lb_config_rom.sv
lb_read_mux.sv
lb_slave_top.sv
lb_slave_properties.sv
tb_lb_slave.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_lb_slave
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST RESULT: PASS

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_lb_slave.sv ====
`default_nettype none

`include "lb_defines.svh"

module tb_lb_slave
	import lb_bus_pkg::*;
();

	// Tests take about 6000 cycles, the limit doubles that
	localparam int TEST_CYCLES = 6000;
	localparam int MAX_CYCLES = 2 * TEST_CYCLES;
	localparam int LED_WRAP = 1 << `LB_LED_CW;

	logic clk;
	logic rst_n;
	logic [`LB_AW-1:0] addr;
	logic control_strobe;
	logic control_rd;
	logic [`LB_DW-1:0] data_out;
	logic xdomain_fault;
	logic tx_mac_done;
	logic [15:0] rx_mac_data;
	logic [1:0] rx_mac_buf_status;
	wire [`LB_DW-1:0] data_in;
	wire rx_mac_hbank;
	wire cfg_d02;
	wire mmc_int;
	wire allow_mmc_eth_config;
	wire zest_pwr_en;
	wire led_user_mode;
	wire led1;
	wire led2;

	int error_count = 0;
	int check_total = 0;
	int cycle_count = 0;
	int fault_total = 0;
	logic [31:0] lfsr_state = 32'hf644;
	// Expected mirror words, updated on every region 5 write
	logic [`LB_DW-1:0] mirror_model [0:(1 << `LB_MIRROR_AW)-1];
	// Board descriptor listed word by word
	logic [15:0] rom_desc [0:7] = '{`LB_ROM_DESC0, `LB_ROM_DESC1, `LB_ROM_DESC2,
		`LB_ROM_DESC3, `LB_ROM_DESC4, `LB_ROM_DESC5, `LB_ROM_DESC6, `LB_ROM_DESC7};

	lb_slave_top DUT (
		.clk(clk), .rst_n(rst_n), .addr(addr), .control_strobe(control_strobe),
		.control_rd(control_rd), .data_out(data_out), .xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done), .rx_mac_data(rx_mac_data),
		.rx_mac_buf_status(rx_mac_buf_status), .data_in(data_in),
		.rx_mac_hbank(rx_mac_hbank), .cfg_d02(cfg_d02), .mmc_int(mmc_int),
		.allow_mmc_eth_config(allow_mmc_eth_config), .zest_pwr_en(zest_pwr_en),
		.led_user_mode(led_user_mode), .led1(led1), .led2(led2)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [`LB_AW-1:0] reg_addr(input logic [7:0] region,
			input logic [11:0] index);
		lb_addr_u a;
		a.reg_view.region = region;
		a.reg_view.reserved = 4'h0;
		a.reg_view.reg_index = index;
		return a;
	endfunction

	// ROM window address, bit 11 set in any page
	function automatic logic [`LB_AW-1:0] rom_addr(input logic [11:0] page,
			input logic [`LB_ROM_AW-1:0] word);
		lb_addr_u a;
		a.rom_view.page = page;
		a.rom_view.rom_sel = 1'b1;
		a.rom_view.rom_addr = word;
		return a;
	endfunction

	// Descriptor in words 0 to 7, zero elsewhere
	function automatic logic [15:0] rom_word(input logic [`LB_ROM_AW-1:0] word);
		if (word < 8)
			return rom_desc[word[2:0]];
		else
			return 16'h0000;
	endfunction

	// One-cycle write strobe
	task automatic lb_write(input logic [`LB_AW-1:0] a, input logic [`LB_DW-1:0] d);
		lb_addr_u u;
		u = a;
		addr = a;
		data_out = d;
		control_strobe = 1'b1;
		control_rd = 1'b0;
		@(posedge clk);
		#2;
		control_strobe = 1'b0;
		if (u.reg_view.region == `LB_REGION_LOCAL)
			mirror_model[u.reg_view.reg_index[`LB_MIRROR_AW-1:0]] = d;
	endtask

	// Strobe, then data_in two edges later
	task automatic lb_read(input logic [`LB_AW-1:0] a, output logic [`LB_DW-1:0] d);
		addr = a;
		control_strobe = 1'b1;
		control_rd = 1'b1;
		@(posedge clk);
		#2;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		@(posedge clk);
		#2;
		d = data_in;
	endtask

	// Two reads in flight
	task automatic lb_read_pair(input logic [`LB_AW-1:0] a0, input logic [`LB_AW-1:0] a1,
			output logic [`LB_DW-1:0] d0, output logic [`LB_DW-1:0] d1);
		addr = a0;
		control_strobe = 1'b1;
		control_rd = 1'b1;
		@(posedge clk);
		#2;
		addr = a1;
		@(posedge clk);
		#2;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		d0 = data_in;
		@(posedge clk);
		#2;
		d1 = data_in;
	endtask

	task automatic check_word(input string name, input logic [`LB_DW-1:0] expected,
			input logic [`LB_DW-1:0] actual);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic reset_values();
		check_bit("reset led_user_mode", 1'b0, led_user_mode);
		check_bit("reset led1", 1'b0, led1);
		check_bit("reset led2", 1'b0, led2);
		check_bit("reset cfg_d02", 1'b0, cfg_d02);
		check_bit("reset mmc_int", 1'b0, mmc_int);
		check_bit("reset allow_mmc_eth_config", 1'b0, allow_mmc_eth_config);
		check_bit("reset zest_pwr_en", 1'b0, zest_pwr_en);
		check_bit("reset rx_mac_hbank", 1'b1, rx_mac_hbank);
		check_word("reset data_in", '0, data_in);
	endtask

	task automatic bank0_reads();
		logic [`LB_DW-1:0] d0;
		logic [`LB_DW-1:0] d1;
		logic [31:0] v;
		int pulses;
		lb_read_pair(reg_addr(`LB_REGION_BANK0, 12'd0), reg_addr(`LB_REGION_BANK0, 12'd1),
			d0, d1);
		check_word("bank0 id0", `LB_ID0, d0);
		check_word("bank0 id1", `LB_ID1, d1);
		lb_read_pair(reg_addr(`LB_REGION_BANK0, 12'd2), reg_addr(`LB_REGION_BANK0, 12'd3),
			d0, d1);
		check_word("bank0 id2", `LB_ID2, d0);
		check_word("bank0 id3", `LB_ID3, d1);
		for (int i = 7; i < 16; i++) begin
			lb_read(reg_addr(`LB_REGION_BANK0, 12'(i)), d0);
			check_word("bank0 unused", `LB_BANK_ZZZZ, d0);
		end
		// Fault pulses, one count per high cycle
		pulses = 1 + rand_bits(4);
		xdomain_fault = 1'b1;
		repeat (pulses) @(posedge clk);
		#2;
		xdomain_fault = 1'b0;
		fault_total += pulses;
		lb_read(reg_addr(`LB_REGION_BANK0, 12'd4), d0);
		check_word("bank0 fault count", {16'h0000, fault_total[15:0]}, d0);
		// MAC status settles through the synchronizer
		for (int i = 0; i < 4; i++) begin
			v = rand_bits(3);
			tx_mac_done = v[0];
			rx_mac_buf_status = v[2:1];
			repeat (2) @(posedge clk);
			#2;
			lb_read(reg_addr(`LB_REGION_BANK0, 12'd5), d0);
			check_word("bank0 mac status", {29'd0, v[2:1], v[0]}, d0);
		end
	endtask

	task automatic direct_writes();
		logic [`LB_DW-1:0] d0;
		logic [`LB_DW-1:0] d1;
		logic [31:0] v;
		logic [`LB_MIRROR_AW-1:0] used [0:19];
		for (int i = 0; i < 3; i++) begin
			v = rand_bits(32);
			lb_write(reg_addr(`LB_REGION_LOCAL, {8'h00, `LB_WR_LED_USER}), v);
			check_bit("write led_user_mode", v[0], led_user_mode);
			v = rand_bits(32);
			lb_write(reg_addr(`LB_REGION_LOCAL, {8'h00, `LB_WR_HBANK}), v);
			check_bit("write rx_mac_hbank", v[0], rx_mac_hbank);
			v = rand_bits(32);
			lb_write(reg_addr(`LB_REGION_LOCAL, {8'h00, `LB_WR_MISC}), v);
			check_bit("write cfg_d02", v[0], cfg_d02);
			check_bit("write mmc_int", v[1], mmc_int);
			check_bit("write allow_mmc_eth_config", v[2], allow_mmc_eth_config);
			check_bit("write zest_pwr_en", v[3], zest_pwr_en);
		end
		for (int i = 0; i < 20; i++) begin
			v = rand_bits(`LB_MIRROR_AW);
			used[i] = v[`LB_MIRROR_AW-1:0];
			lb_write(reg_addr(`LB_REGION_LOCAL, {7'h00, used[i]}), rand_bits(32));
		end
		for (int i = 0; i < 10; i++) begin
			lb_read(reg_addr(`LB_REGION_LOCAL, {7'h00, used[i]}), d0);
			check_word("mirror read", mirror_model[used[i]], d0);
		end
		// Back-to-back pairs over the rest
		for (int i = 10; i < 20; i += 2) begin
			lb_read_pair(reg_addr(`LB_REGION_LOCAL, {7'h00, used[i]}),
				reg_addr(`LB_REGION_LOCAL, {7'h00, used[i+1]}), d0, d1);
			check_word("mirror pair first", mirror_model[used[i]], d0);
			check_word("mirror pair second", mirror_model[used[i+1]], d1);
		end
	endtask

	task automatic region_decode();
		logic [`LB_DW-1:0] d;
		logic [31:0] v;
		logic [7:0] region;
		logic [11:0] page;
		logic [`LB_ROM_AW-1:0] word;
		for (int i = 0; i < 4; i++) begin
			v = rand_bits(28);
			rx_mac_data = v[15:0];
			lb_read(reg_addr(`LB_REGION_MAC, v[27:16]), d);
			check_word("region 3 mac data", {16'h0000, v[15:0]}, d);
		end
		for (int i = 0; i < 6; i++) begin
			v = rand_bits(19);
			region = v[7:0];
			if (region == `LB_REGION_BANK0 || region == `LB_REGION_MAC ||
					region == `LB_REGION_LOCAL)
				region = region | 8'h10;
			lb_read(reg_addr(region, {1'b0, v[18:8]}), d);
			check_word("unmapped region", `LB_DEAD_WORD, d);
		end
		for (int i = 0; i < 12; i++) begin
			v = rand_bits(24);
			page = (i == 0) ? 12'h000 : v[11:0];
			// Regions 3 and 5 take priority over the ROM window
			if (page[11:4] == `LB_REGION_MAC || page[11:4] == `LB_REGION_LOCAL)
				page[11] = 1'b1;
			word = v[23] ? v[22:12] : {8'h00, v[14:12]};
			lb_read(rom_addr(page, word), d);
			check_word("rom window", {16'h0000, rom_word(word)}, d);
		end
	endtask

	// High-cycle count over one full LED wrap
	task automatic pwm_duty(input int d1, input int d2);
		int high1;
		int high2;
		int exp1;
		int exp2;
		lb_write(reg_addr(`LB_REGION_LOCAL, {8'h00, `LB_WR_LED1_DF}), d1);
		lb_write(reg_addr(`LB_REGION_LOCAL, {8'h00, `LB_WR_LED2_DF}), d2);
		repeat (2) @(posedge clk);
		#2;
		high1 = 0;
		high2 = 0;
		repeat (LED_WRAP) begin
			@(posedge clk);
			#2;
			if (led1)
				high1++;
			if (led2)
				high2++;
		end
		exp1 = (4 * d1 > LED_WRAP) ? LED_WRAP : 4 * d1;
		exp2 = (4 * d2 > LED_WRAP) ? LED_WRAP : 4 * d2;
		check_count("pwm led1", exp1[15:0], high1[15:0]);
		check_count("pwm led2", exp2[15:0], high2[15:0]);
	endtask

	task automatic uptime_rate();
		logic [`LB_DW-1:0] u0;
		logic [`LB_DW-1:0] u1;
		logic [31:0] diff;
		lb_read(reg_addr(`LB_REGION_BANK0, 12'd6), u0);
		repeat (3 * LED_WRAP) @(posedge clk);
		#2;
		lb_read(reg_addr(`LB_REGION_BANK0, 12'd6), u1);
		diff = u1 - u0;
		// Three wraps, one tick of slack either way
		check_total++;
		if (diff < 2 || diff > 4) begin
			error_count++;
			$display("Mismatch in uptime: expected 3 +/- 1, actual %0d", diff);
		end
	endtask

	initial begin
		int d1;
		int d2;
		rst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_data = '0;
		rx_mac_buf_status = '0;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		reset_values();
		bank0_reads();
		direct_writes();
		region_decode();
		d1 = rand_bits(`LB_LED_CW - 2);
		d2 = rand_bits(`LB_LED_CW - 2);
		pwm_duty(d1, d2);
		// Duty extremes, off and full scale
		pwm_duty(0, (1 << (`LB_LED_CW - 2)) - 1);
		uptime_rate();
		$display("Checks: %0d, errors: %0d", check_total, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lb_slave_properties.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_slave_properties (
	input wire clk,
	input wire rst_n,
	input wire rd_stb_d,
	input wire [`LB_DW-1:0] data_in,
	input wire rx_mac_hbank,
	input wire led1,
	input wire led2
);

	// High receive bank right out of reset
	hbank_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> rx_mac_hbank)
		else $error("rx_mac_hbank low in the first cycle after reset");

	// Read data moves only behind a second-stage strobe
	data_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(data_in) |-> $past(rd_stb_d))
		else $error("data_in changed without a read in its second stage");

	// No X on LEDs or read data
	outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({led1, led2, data_in}))
		else $error("led1, led2 or data_in unknown after reset");

endmodule

// Second-stage strobe taken from inside the top level
bind lb_slave_top lb_slave_properties u_props (
	.clk(clk), .rst_n(rst_n), .rd_stb_d(rd_stb_d), .data_in(data_in),
	.rx_mac_hbank(rx_mac_hbank), .led1(led1), .led2(led2)
);

`default_nettype wire

// ==== lb_slave_top.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_slave_top (
	input wire clk,
	input wire rst_n,
	input wire [`LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	input wire [`LB_DW-1:0] data_out,
	input wire xdomain_fault,
	input wire tx_mac_done,
	input wire [15:0] rx_mac_data,
	input wire [1:0] rx_mac_buf_status,
	output wire [`LB_DW-1:0] data_in,
	output wire rx_mac_hbank,
	output wire cfg_d02,
	output wire mmc_int,
	output wire allow_mmc_eth_config,
	output wire zest_pwr_en,
	output wire led_user_mode,
	output wire led1,
	output wire led2
);

	// Decode outputs
	wire rd_stb;
	wire rd_stb_d;
	wire local_wr;
	wire [3:0] wr_index;
	wire [7:0] region_d;
	wire rom_sel_d;

	// Execute results feeding the read path
	wire [15:0] fault_count;
	wire [2:0] mac_status;
	wire [31:0] uptime;
	wire [`LB_DW-1:0] mirror_out;
	wire [15:0] rom_out;

	// Strobe and address decode
	lb_addr_decode u_decode (
		.clk(clk), .rst_n(rst_n), .addr(addr),
		.control_strobe(control_strobe), .control_rd(control_rd),
		.rd_stb(rd_stb), .rd_stb_d(rd_stb_d), .local_wr(local_wr),
		.wr_index(wr_index), .region_d(region_d), .rom_sel_d(rom_sel_d)
	);

	// Board control registers and counters
	lb_ctrl_regs u_ctrl (
		.clk(clk), .rst_n(rst_n), .local_wr(local_wr), .wr_index(wr_index),
		.data_out(data_out), .xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done), .rx_mac_buf_status(rx_mac_buf_status),
		.fault_count(fault_count), .mac_status(mac_status), .uptime(uptime),
		.led_user_mode(led_user_mode), .led1(led1), .led2(led2),
		.rx_mac_hbank(rx_mac_hbank), .cfg_d02(cfg_d02), .mmc_int(mmc_int),
		.allow_mmc_eth_config(allow_mmc_eth_config), .zest_pwr_en(zest_pwr_en)
	);

	// Readback copy of region 5 writes
	lb_mirror_ram u_mirror (
		.clk(clk), .addr(addr), .local_wr(local_wr), .data_out(data_out),
		.mirror_out(mirror_out)
	);

	lb_config_rom u_rom (
		.clk(clk), .addr(addr), .rom_out(rom_out)
	);

	// Two-stage read result
	lb_read_mux u_rdmux (
		.clk(clk), .rst_n(rst_n), .addr(addr), .rd_stb(rd_stb), .rd_stb_d(rd_stb_d),
		.region_d(region_d), .rom_sel_d(rom_sel_d), .fault_count(fault_count),
		.mac_status(mac_status), .uptime(uptime), .rx_mac_data(rx_mac_data),
		.mirror_out(mirror_out), .rom_out(rom_out), .data_in(data_in)
	);

endmodule

`default_nettype wire

// ==== lb_read_mux.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_read_mux
	import lb_bus_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire [`LB_AW-1:0] addr,
	input wire rd_stb,
	input wire rd_stb_d,
	input wire [7:0] region_d,
	input wire rom_sel_d,
	input wire [15:0] fault_count,
	input wire [2:0] mac_status,
	input wire [31:0] uptime,
	input wire [15:0] rx_mac_data,
	input wire [`LB_DW-1:0] mirror_out,
	input wire [15:0] rom_out,
	output logic [`LB_DW-1:0] data_in
);

	lb_addr_u a;
	logic [`LB_DW-1:0] bank_word;

	assign a = addr;

	// First stage, bank 0 captured with the strobe
	always_ff @(posedge clk) begin
		if (rd_stb) begin
			case (a.reg_view.reg_index[3:0])
				4'h0: bank_word <= `LB_ID0;
				4'h1: bank_word <= `LB_ID1;
				4'h2: bank_word <= `LB_ID2;
				4'h3: bank_word <= `LB_ID3;
				4'h4: bank_word <= {16'h0000, fault_count};
				4'h5: bank_word <= {29'd0, mac_status};
				4'h6: bank_word <= uptime;
				default: bank_word <= `LB_BANK_ZZZZ;
			endcase
		end
	end

	// Second stage, region pick in priority order
	// Held until the next read reaches this stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (rd_stb_d) begin
			if (region_d == `LB_REGION_MAC)
				data_in <= {16'h0000, rx_mac_data};
			else if (region_d == `LB_REGION_LOCAL)
				data_in <= mirror_out;
			// ROM window beats bank 0 but not regions 3 and 5
			else if (rom_sel_d)
				data_in <= {16'h0000, rom_out};
			else if (region_d == `LB_REGION_BANK0)
				data_in <= bank_word;
			else
				data_in <= `LB_DEAD_WORD;
		end
	end

endmodule

`default_nettype wire

// ==== lb_config_rom.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_config_rom
	import lb_bus_pkg::*;
(
	input wire clk,
	input wire [`LB_AW-1:0] addr,
	output logic [15:0] rom_out
);

	lb_addr_u a;

	assign a = addr;

	// Registered lookup, read every cycle
	// Only the descriptor is populated
	always_ff @(posedge clk) begin
		case (a.rom_view.rom_addr)
			`LB_ROM_AW'd0: rom_out <= `LB_ROM_DESC0;
			`LB_ROM_AW'd1: rom_out <= `LB_ROM_DESC1;
			`LB_ROM_AW'd2: rom_out <= `LB_ROM_DESC2;
			`LB_ROM_AW'd3: rom_out <= `LB_ROM_DESC3;
			`LB_ROM_AW'd4: rom_out <= `LB_ROM_DESC4;
			`LB_ROM_AW'd5: rom_out <= `LB_ROM_DESC5;
			`LB_ROM_AW'd6: rom_out <= `LB_ROM_DESC6;
			`LB_ROM_AW'd7: rom_out <= `LB_ROM_DESC7;
			// Rest of the 2K reads as zero
			default: rom_out <= 16'h0000;
		endcase
	end

endmodule

`default_nettype wire

// ==== lb_mirror_ram.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_mirror_ram
	import lb_bus_pkg::*;
(
	input wire clk,
	input wire [`LB_AW-1:0] addr,
	input wire local_wr,
	input wire [`LB_DW-1:0] data_out,
	output logic [`LB_DW-1:0] mirror_out
);

	localparam int DEPTH = 1 << `LB_MIRROR_AW;

	lb_addr_u a;
	logic [`LB_MIRROR_AW-1:0] mem_addr;
	logic [`LB_DW-1:0] mem [0:DEPTH-1];

	assign a = addr;
	// Low index bits pick the word, any register in region 5 lands here too
	assign mem_addr = a.reg_view.reg_index[`LB_MIRROR_AW-1:0];

	// Read sees the old word on a same-cycle write
	always_ff @(posedge clk) begin
		if (local_wr)
			mem[mem_addr] <= data_out;
		mirror_out <= mem[mem_addr];
	end

endmodule

`default_nettype wire

// ==== lb_ctrl_regs.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_ctrl_regs (
	input wire clk,
	input wire rst_n,
	input wire local_wr,
	input wire [3:0] wr_index,
	input wire [`LB_DW-1:0] data_out,
	input wire xdomain_fault,
	input wire tx_mac_done,
	input wire [1:0] rx_mac_buf_status,
	output logic [15:0] fault_count,
	output logic [2:0] mac_status,
	output logic [31:0] uptime,
	output logic led_user_mode,
	output logic led1,
	output logic led2,
	output logic rx_mac_hbank,
	output logic cfg_d02,
	output logic mmc_int,
	output logic allow_mmc_eth_config,
	output logic zest_pwr_en
);

	// Duty registers are two bits short of the counter
	localparam int DUTY_W = `LB_LED_CW - 2;

	logic [DUTY_W-1:0] led1_df;
	logic [DUTY_W-1:0] led2_df;
	logic [3:0] misc_cfg;
	logic [`LB_LED_CW-1:0] led_cc;
	logic led_tick;
	logic tx_mac_done_r;
	logic [1:0] rx_mac_buf_status_r;

	// Direct writes, low data bits only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user_mode <= 1'b0;
			led1_df <= '0;
			led2_df <= '0;
			// Host starts on the high receive bank
			rx_mac_hbank <= 1'b1;
			misc_cfg <= 4'b0000;
		end else if (local_wr) begin
			case (wr_index)
				`LB_WR_LED_USER: led_user_mode <= data_out[0];
				`LB_WR_LED1_DF: led1_df <= data_out[DUTY_W-1:0];
				`LB_WR_LED2_DF: led2_df <= data_out[DUTY_W-1:0];
				`LB_WR_HBANK: rx_mac_hbank <= data_out[0];
				`LB_WR_MISC: misc_cfg <= data_out[3:0];
				default: ;
			endcase
		end
	end

	// Misc bits straight to the board pins
	assign cfg_d02 = misc_cfg[0];
	assign mmc_int = misc_cfg[1];
	assign allow_mmc_eth_config = misc_cfg[2];
	assign zest_pwr_en = misc_cfg[3];

	// Free LED counter, carry out marks a wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cc <= '0;
			led_tick <= 1'b0;
		end else begin
			{led_tick, led_cc} <= led_cc + 1'b1;
		end
	end

	// PWM compare, high for 4*duty counts of every wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {led1_df, 2'b00};
			led2 <= led_cc < {led2_df, 2'b00};
		end
	end

	// Coarse uptime, one count per LED wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			uptime <= '0;
		else if (led_tick)
			uptime <= uptime + 1'b1;
	end

	// Cross-domain fault pulses, wraps at 16 bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fault_count <= '0;
		else if (xdomain_fault)
			fault_count <= fault_count + 1'b1;
	end

	// MAC status brought into clk before it reaches bank 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_mac_done_r <= 1'b0;
			rx_mac_buf_status_r <= 2'b00;
		end else begin
			tx_mac_done_r <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// Buffer status on top, done flag at bit 0
	assign mac_status = {rx_mac_buf_status_r, tx_mac_done_r};

endmodule

`default_nettype wire

// ==== lb_addr_decode.sv ====
`default_nettype none

`include "lb_defines.svh"

module lb_addr_decode
	import lb_bus_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire [`LB_AW-1:0] addr,
	input wire control_strobe,
	input wire control_rd,
	output logic rd_stb,
	output logic rd_stb_d,
	output logic local_wr,
	output logic [3:0] wr_index,
	output logic [7:0] region_d,
	output logic rom_sel_d
);

	lb_addr_u a;

	assign a = addr;

	// Read is strobe with rd high, write is strobe with rd low
	assign rd_stb = control_strobe & control_rd;

	// Only region 5 takes direct writes
	assign local_wr = control_strobe & ~control_rd &
		(a.reg_view.region == `LB_REGION_LOCAL);

	// Low nibble picks the control register
	assign wr_index = a.reg_view.reg_index[3:0];

	// Second read stage controls, one cycle behind the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_stb_d <= 1'b0;
			region_d <= 8'd0;
			rom_sel_d <= 1'b0;
		end else begin
			rd_stb_d <= rd_stb;
			region_d <= a.reg_view.region;
			// Bit 11 seen through the ROM view
			rom_sel_d <= a.rom_view.rom_sel;
		end
	end

endmodule

`default_nettype wire

// ==== lb_bus_pkg.sv ====
`default_nettype none

`include "lb_defines.svh"

package lb_bus_pkg;

	// Register view of the local-bus address
	// Region in the top byte, index in the low twelve bits
	typedef struct packed {
		logic [7:0] region;
		logic [3:0] reserved;
		logic [11:0] reg_index;
	} lb_addr_region_t;

	// ROM view of the same word
	// Bit 11 opens the 2K ROM window in any page
	typedef struct packed {
		logic [11:0] page;
		logic rom_sel;
		logic [`LB_ROM_AW-1:0] rom_addr;
	} lb_addr_rom_t;

	// One address, two decodings
	typedef union packed {
		lb_addr_region_t reg_view;
		lb_addr_rom_t rom_view;
	} lb_addr_u;

endpackage

`default_nettype wire

// ==== lb_defines.svh ====
`ifndef LB_DEFINES_SVH
`define LB_DEFINES_SVH

// Bus widths
`define LB_AW 24
`define LB_DW 32

// Region numbers, compared against addr[23:16]
`define LB_REGION_BANK0 8'd0
`define LB_REGION_MAC 8'd3
`define LB_REGION_LOCAL 8'd5

// Storage sizes
`define LB_MIRROR_AW 5
`define LB_ROM_AW 11

// LED PWM counter, one wrap is one uptime tick
`define LB_LED_CW 10

// Answer for unmapped reads
`define LB_DEAD_WORD 32'hdeadbeef

// Identification string "Hello world!(::)"
`define LB_ID0 32'h48656c6c
`define LB_ID1 32'h6f20776f
`define LB_ID2 32'h726c6421
`define LB_ID3 32'h283a3a29
// "zzzz" for unused bank-0 slots
`define LB_BANK_ZZZZ 32'h7a7a7a7a

// Direct-write register indices in region 5
`define LB_WR_LED_USER 4'd1
`define LB_WR_LED1_DF 4'd2
`define LB_WR_LED2_DF 4'd3
`define LB_WR_HBANK 4'd5
`define LB_WR_MISC 4'd8

// Board descriptor at the start of the config ROM
`define LB_ROM_DESC0 16'h4c42
`define LB_ROM_DESC1 16'h0001
`define LB_ROM_DESC2 16'h0800
`define LB_ROM_DESC3 16'h0010
`define LB_ROM_DESC4 16'h0005
`define LB_ROM_DESC5 16'h0020
`define LB_ROM_DESC6 16'h0003
`define LB_ROM_DESC7 16'ha55a

`endif
